//--- verilog/fp_conv_pkg.sv
// ======================================
// shared constants for the converter subsystem
// IEEE-754 single precision only, no denormal outputs
// ======================================
package fp_conv_pkg;

        localparam int word_w   = 32;
        localparam int exp_w    = 8;
        localparam int man_w    = 23; // stored fraction bits, hidden bit excluded
        localparam int exp_bias = 127;
        localparam int adr_w    = 2;  // word address, four registers

        // register map
        localparam logic [adr_w-1:0] reg_operand = 2'd0; // read/write
        localparam logic [adr_w-1:0] reg_ctrl    = 2'd1; // write-only, reads zero
        localparam logic [adr_w-1:0] reg_status  = 2'd2; // read-only
        localparam logic [adr_w-1:0] reg_result  = 2'd3; // read-only

        // control word, 0 is int to float, 1 is float to int
        localparam int ctrl_dir_bit = 0;

        // status word
        localparam int stat_busy_bit = 0;
        localparam int stat_done_bit = 1;

        // saturation limits for float to int
        localparam logic [word_w-1:0] int_min = 32'h8000_0000;
        localparam logic [word_w-1:0] int_max = 32'h7fff_ffff;

endpackage

//--- verilog/int_to_float.sv
// ======================================
// start is only honoured while idle
// latency 3 cycles for zero, else 5 plus leading zeros
// ======================================
`timescale 1ns/10ps

module int_to_float (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            start,
        input  logic [fp_conv_pkg::word_w-1:0]  operand,
        output logic [fp_conv_pkg::word_w-1:0]  result,
        output logic                            done
);

        localparam int word_w = fp_conv_pkg::word_w;
        localparam int exp_w  = fp_conv_pkg::exp_w;
        localparam int man_w  = fp_conv_pkg::man_w;
        localparam int lo_w   = word_w - man_w - 1;  // bits below the kept mantissa

        // biased exponent of a value whose top bit sits at position word_w-1
        localparam logic [exp_w-1:0] exp_top = exp_w'(fp_conv_pkg::exp_bias + word_w - 1);

        typedef enum logic [2:0] {
                st_idle,
                st_convert,
                st_norm,
                st_round,
                st_pack
        } state_t;

        state_t state;

        logic              sign;
        logic [exp_w-1:0]  exp_q;   // kept biased throughout
        logic [word_w-1:0] mag;
        logic [man_w:0]    man;     // hidden bit included
        logic              rnd_up;

        // round to nearest, ties to even, on the normalized magnitude
        assign rnd_up = mag[lo_w-1] & (mag[lo_w-2] | (|mag[lo_w-3:0]) | mag[lo_w]);

        always_ff @(posedge clk) begin
                if (!rst) begin
                        state <= st_idle;
                        done  <= 1'b0;
                end else begin
                        done <= 1'b0;
                        case (state)
                        st_idle: begin
                                if (start) begin
                                        sign  <= operand[word_w-1];
                                        mag   <= operand[word_w-1] ? -operand : operand;
                                        state <= st_convert;
                                end
                        end
                        st_convert: begin
                                if (mag == '0) begin
                                        exp_q <= '0; // packs as +0
                                        man   <= '0;
                                        state <= st_pack;
                                end else begin
                                        exp_q <= exp_top;
                                        state <= st_norm;
                                end
                        end
                        st_norm: begin
                                // one bit per cycle until the leading one is at the top
                                if (!mag[word_w-1]) begin
                                        mag   <= mag << 1;
                                        exp_q <= exp_q - 1'b1;
                                end else begin
                                        state <= st_round;
                                end
                        end
                        st_round: begin
                                man <= mag[word_w-1 -: man_w+1] + (man_w+1)'(rnd_up);
                                if (rnd_up && (&mag[word_w-1 -: man_w+1]))
                                        exp_q <= exp_q + 1'b1; // mantissa overflow
                                state <= st_pack;
                        end
                        st_pack: begin
                                result <= {sign, exp_q, man[man_w-1:0]};
                                done   <= 1'b1;
                                state  <= st_idle;
                        end
                        default: state <= st_idle;
                        endcase
                end
        end

endmodule

//--- verilog/float_to_int.sv
// ======================================
// fixed 3 cycle pipeline, truncates toward zero
// out of range and NaN saturate, NaN gives int_min
// ======================================
`timescale 1ns/10ps

module float_to_int (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            start,
        input  logic [fp_conv_pkg::word_w-1:0]  operand,
        output logic [fp_conv_pkg::word_w-1:0]  result,
        output logic                            done
);

        localparam int word_w = fp_conv_pkg::word_w;
        localparam int exp_w  = fp_conv_pkg::exp_w;
        localparam int man_w  = fp_conv_pkg::man_w;
        localparam int sh_w   = $clog2(word_w);
        localparam int pad_w  = word_w - man_w - 2;

        // largest biased exponent whose value still fits a signed word
        localparam logic [exp_w-1:0] exp_fit  = exp_w'(fp_conv_pkg::exp_bias + word_w - 2);
        localparam logic [exp_w-1:0] exp_one  = exp_w'(fp_conv_pkg::exp_bias);
        localparam logic [exp_w-1:0] exp_nan  = '1;

        logic [exp_w-1:0]  f_exp;
        logic [man_w-1:0]  f_frac;
        logic [exp_w-1:0]  sh_full;

        // stage one
        logic              v1, zero1, sat1, neg1;
        logic [man_w-1:0]  frac1;
        logic [sh_w-1:0]   sh1;

        // stage two
        logic              v2, sat2, neg2;
        logic [word_w-1:0] mag2;

        assign f_exp   = operand[word_w-2 -: exp_w];
        assign f_frac  = operand[man_w-1:0];
        assign sh_full = exp_fit - f_exp;

        always_ff @(posedge clk) begin
                if (!rst) begin
                        v1   <= 1'b0;
                        v2   <= 1'b0;
                        done <= 1'b0;
                end else begin
                        v1   <= start;
                        v2   <= v1;
                        done <= v2;
                end
        end

        // unpack and classify
        always_ff @(posedge clk) begin
                zero1 <= f_exp < exp_one;                // magnitude below one
                sat1  <= f_exp > exp_fit;                // also catches inf and NaN
                neg1  <= operand[word_w-1] | ((f_exp == exp_nan) && (f_frac != '0));
                frac1 <= f_frac;
                sh1   <= sh_full[sh_w-1:0];
        end

        // barrel shift of {1.frac} placed just below the sign bit
        always_ff @(posedge clk) begin
                sat2 <= sat1;
                neg2 <= neg1;
                if (zero1)
                        mag2 <= '0;
                else
                        mag2 <= {1'b0, 1'b1, frac1, {pad_w{1'b0}}} >> sh1;
        end

        // sign and saturation, -2^31 lands on int_min through the sat path
        always_ff @(posedge clk) begin
                if (sat2)
                        result <= neg2 ? fp_conv_pkg::int_min : fp_conv_pkg::int_max;
                else
                        result <= neg2 ? -mag2 : mag2;
        end

endmodule

//--- verilog/fp_conv_wb_regs.sv
// ======================================
// wishbone classic slave, every access acked after one cycle
// control writes while busy are acked and dropped
// ======================================
`timescale 1ns/10ps

module fp_conv_wb_regs (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            wb_cyc,
        input  logic                            wb_stb,
        input  logic                            wb_we,
        input  logic [fp_conv_pkg::adr_w-1:0]   wb_adr,
        input  logic [fp_conv_pkg::word_w-1:0]  wb_dat_w,
        output logic [fp_conv_pkg::word_w-1:0]  wb_dat_r,
        output logic                            wb_ack,
        input  logic [fp_conv_pkg::word_w-1:0]  i2f_result,
        input  logic                            i2f_done,
        input  logic [fp_conv_pkg::word_w-1:0]  f2i_result,
        input  logic                            f2i_done,
        output logic                            i2f_start,
        output logic                            f2i_start,
        output logic [fp_conv_pkg::word_w-1:0]  operand
);

        localparam int word_w = fp_conv_pkg::word_w;

        logic              access;
        logic              wr_ctrl;
        logic              dir_q;      // 1 while a float to int conversion runs
        logic              busy;
        logic              done_flag;
        logic              conv_done;
        logic [word_w-1:0] result_q;
        logic [word_w-1:0] status;

        assign access    = wb_cyc & wb_stb & ~wb_ack;
        assign wr_ctrl   = access & wb_we & (wb_adr == fp_conv_pkg::reg_ctrl);
        assign conv_done = dir_q ? f2i_done : i2f_done; // only the running converter counts

        always_comb begin
                status = '0;
                status[fp_conv_pkg::stat_busy_bit] = busy;
                status[fp_conv_pkg::stat_done_bit] = done_flag;
        end

        // control state and bus handshake
        always_ff @(posedge clk) begin
                if (!rst) begin
                        wb_ack    <= 1'b0;
                        i2f_start <= 1'b0;
                        f2i_start <= 1'b0;
                        dir_q     <= 1'b0;
                        busy      <= 1'b0;
                        done_flag <= 1'b0;
                end else begin
                        wb_ack    <= access;
                        i2f_start <= 1'b0;
                        f2i_start <= 1'b0;
                        if (wr_ctrl && !busy) begin
                                dir_q     <= wb_dat_w[fp_conv_pkg::ctrl_dir_bit];
                                i2f_start <= ~wb_dat_w[fp_conv_pkg::ctrl_dir_bit];
                                f2i_start <= wb_dat_w[fp_conv_pkg::ctrl_dir_bit];
                                busy      <= 1'b1;
                                done_flag <= 1'b0;
                        end else if (busy && conv_done) begin
                                busy      <= 1'b0;
                                done_flag <= 1'b1;
                        end
                end
        end

        // payload registers
        always_ff @(posedge clk) begin
                if (access && wb_we && (wb_adr == fp_conv_pkg::reg_operand))
                        operand <= wb_dat_w;
                if (busy && conv_done)
                        result_q <= dir_q ? f2i_result : i2f_result;
        end

        // read data held through the ack cycle
        always_ff @(posedge clk) begin
                if (access && !wb_we) begin
                        case (wb_adr)
                        fp_conv_pkg::reg_operand: wb_dat_r <= operand;
                        fp_conv_pkg::reg_status:  wb_dat_r <= status;
                        fp_conv_pkg::reg_result:  wb_dat_r <= result_q;
                        default:                  wb_dat_r <= '0; // ctrl reads zero
                        endcase
                end
        end

endmodule

//--- verilog/fp_conv_top.sv
// ======================================
// bus slave plus both converters, no parameters
// ======================================
`timescale 1ns/10ps

module fp_conv_top (
        input  logic                            clk,
        input  logic                            rst,
        input  logic                            wb_cyc,
        input  logic                            wb_stb,
        input  logic                            wb_we,
        input  logic [fp_conv_pkg::adr_w-1:0]   wb_adr,
        input  logic [fp_conv_pkg::word_w-1:0]  wb_dat_w,
        output logic [fp_conv_pkg::word_w-1:0]  wb_dat_r,
        output logic                            wb_ack
);

        logic [fp_conv_pkg::word_w-1:0] operand;
        logic [fp_conv_pkg::word_w-1:0] i2f_result;
        logic [fp_conv_pkg::word_w-1:0] f2i_result;
        logic                           i2f_start, i2f_done;
        logic                           f2i_start, f2i_done;

        fp_conv_wb_regs regs_i (
                .clk        (clk),
                .rst        (rst),
                .wb_cyc     (wb_cyc),
                .wb_stb     (wb_stb),
                .wb_we      (wb_we),
                .wb_adr     (wb_adr),
                .wb_dat_w   (wb_dat_w),
                .wb_dat_r   (wb_dat_r),
                .wb_ack     (wb_ack),
                .i2f_result (i2f_result),
                .i2f_done   (i2f_done),
                .f2i_result (f2i_result),
                .f2i_done   (f2i_done),
                .i2f_start  (i2f_start),
                .f2i_start  (f2i_start),
                .operand    (operand)
        );

        int_to_float i2f_i (
                .clk     (clk),
                .rst     (rst),
                .start   (i2f_start),
                .operand (operand),
                .result  (i2f_result),
                .done    (i2f_done)
        );

        float_to_int f2i_i (
                .clk     (clk),
                .rst     (rst),
                .start   (f2i_start),
                .operand (operand),
                .result  (f2i_result),
                .done    (f2i_done)
        );

endmodule

//--- verif/fp_conv_sva.sv
// ========================================
// protocol and handshake checks, bound into fp_conv_top
// start is assumed to reach a converter only while it is idle
// ========================================
`timescale 1ns/10ps

module fp_conv_sva (
        input logic clk,
        input logic rst,
        input logic wb_cyc,
        input logic wb_stb,
        input logic wb_ack,
        input logic i2f_start,
        input logic i2f_done,
        input logic f2i_start,
        input logic f2i_done
);

        int   sva_errors = 0;
        logic i2f_running;
        logic f2i_running;

        // one pending conversion per converter
        always_ff @(posedge clk) begin
                if (!rst) begin
                        i2f_running <= 1'b0;
                        f2i_running <= 1'b0;
                end else begin
                        if (i2f_start)
                                i2f_running <= 1'b1;
                        else if (i2f_done)
                                i2f_running <= 1'b0;
                        if (f2i_start)
                                f2i_running <= 1'b1;
                        else if (f2i_done)
                                f2i_running <= 1'b0;
                end
        end

        ack_pulse: assert property (@(posedge clk) disable iff (!rst) wb_ack |=> !wb_ack)
                else begin
                        $error("wb_ack stayed high for more than one cycle");
                        sva_errors++;
                end

        ack_after_req: assert property (@(posedge clk) disable iff (!rst)
                        wb_ack |-> $past(wb_cyc && wb_stb && !wb_ack))
                else begin
                        $error("wb_ack without a pending cyc and stb");
                        sva_errors++;
                end

        i2f_one_done: assert property (@(posedge clk) disable iff (!rst)
                        (i2f_start |-> !i2f_running) and (i2f_done |-> i2f_running))
                else begin
                        $error("int_to_float start and done out of order");
                        sva_errors++;
                end

        f2i_one_done: assert property (@(posedge clk) disable iff (!rst)
                        (f2i_start |-> !f2i_running) and (f2i_done |-> f2i_running))
                else begin
                        $error("float_to_int start and done out of order");
                        sva_errors++;
                end

        i2f_latency: assert property (@(posedge clk) disable iff (!rst)
                        i2f_start |-> ##[3:36] i2f_done)
                else begin
                        $error("int_to_float done outside 3 to 36 cycles");
                        sva_errors++;
                end

        f2i_latency: assert property (@(posedge clk) disable iff (!rst)
                        f2i_start |-> ##3 f2i_done)
                else begin
                        $error("float_to_int done not 3 cycles after start");
                        sva_errors++;
                end

        quiet_after_reset: assert property (@(posedge clk)
                        !rst |=> !(wb_ack || i2f_start || f2i_start || i2f_done || f2i_done))
                else begin
                        $error("output active in the cycle after reset");
                        sva_errors++;
                end

endmodule

//--- verif/fp_conv_tb.sv
// ========================================
// testbench for fp_conv_top over wishbone classic
// inputs change on the falling edge, random values from an LCG
// ========================================
`timescale 1ns/10ps

module fp_conv_tb;

        localparam int timeout_cycles = 20000; // ~340 conversions at up to 50 cycles
        localparam logic [31:0] st_busy  = 32'd1 << fp_conv_pkg::stat_busy_bit;
        localparam logic [31:0] st_done  = 32'd1 << fp_conv_pkg::stat_done_bit;
        localparam logic [31:0] ctrl_f2i = 32'd1 << fp_conv_pkg::ctrl_dir_bit;

        // integer operands with exact float images, then rounding cases
        localparam logic [31:0] i2f_in [0:9] = '{
                32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h0100_0000, 32'h00ff_ffff,
                32'hff00_0000, 32'h0100_0001, 32'h0100_0003, 32'h7fff_ffff, 32'h8000_0000};
        localparam logic [31:0] i2f_exp [0:9] = '{
                32'h0000_0000, 32'h3f80_0000, 32'hbf80_0000, 32'h4b80_0000, 32'h4b7f_ffff,
                32'hcb80_0000, 32'h4b80_0000, 32'h4b80_0002, 32'h4f00_0000, 32'hcf00_0000};

        // float corners, truncation then saturation
        localparam logic [31:0] f2i_in [0:13] = '{
                32'h3fc0_0000, 32'hbfc0_0000, 32'h3f40_0000, 32'hbf00_0000, 32'h8000_0000,
                32'h407f_ffff, 32'hc2f6_0000, 32'h4eff_ffff, 32'h4f00_0000, 32'hcf00_0000,
                32'h7f80_0000, 32'hff80_0000, 32'h7fc0_0000, 32'h5015_02f9};
        localparam logic [31:0] f2i_exp [0:13] = '{
                32'h0000_0001, 32'hffff_ffff, 32'h0000_0000, 32'h0000_0000, 32'h0000_0000,
                32'h0000_0003, 32'hffff_ff85, 32'h7fff_ff80, 32'h7fff_ffff, 32'h8000_0000,
                32'h7fff_ffff, 32'h8000_0000, 32'h8000_0000, 32'h7fff_ffff};

        logic                           clk;
        logic                           rst;
        logic                           wb_cyc, wb_stb, wb_we, wb_ack;
        logic [fp_conv_pkg::adr_w-1:0]  wb_adr;
        logic [31:0]                    wb_dat_w, wb_dat_r;
        logic [31:0]                    lcg_state;
        int                             errors, checks, tests_passed, tests_failed;
        int                             test_mark, cycles;

        fp_conv_top dut_i (.*);

        bind fp_conv_top fp_conv_sva sva_i (
                .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
                .i2f_start(i2f_start), .i2f_done(i2f_done),
                .f2i_start(f2i_start), .f2i_done(f2i_done));

        initial begin
                clk = 1'b0;
                forever #10 clk = ~clk;
        end

        function automatic logic [31:0] lcg_next();
                lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
                return lcg_state;
        endfunction

        // nearest even rounding of the magnitude to 24 significant bits
        function automatic logic [31:0] i2f_model(input logic [31:0] v);
                logic [31:0] mag, kept, rem, half;
                int          msb, sh, e, i;
                mag = v[31] ? ~v + 32'd1 : v;
                if (mag == 0)
                        return 32'd0;
                msb = 0;
                for (i = 0; i < 32; i++)
                        if (mag[i]) msb = i;
                e = fp_conv_pkg::exp_bias + msb;
                if (msb <= 23) begin
                        kept = mag << (23 - msb);
                end else begin
                        sh   = msb - 23;
                        kept = mag >> sh;
                        rem  = mag & ((32'd1 << sh) - 32'd1);
                        half = 32'd1 << (sh - 1);
                        if (rem > half || (rem == half && kept[0]))
                                kept = kept + 32'd1;
                        if (kept[24]) begin // carry out of the significand
                                kept = kept >> 1;
                                e    = e + 1;
                        end
                end
                return {v[31], e[7:0], kept[22:0]};
        endfunction

        function automatic logic [31:0] f2i_model(input logic [31:0] v);
                logic [63:0] mag;
                int          p;
                if (v[30:23] == 8'hff && v[22:0] != 0)
                        return fp_conv_pkg::int_min;
                if (v[30:23] < fp_conv_pkg::exp_bias)
                        return 32'd0;
                if (v[30:23] >= fp_conv_pkg::exp_bias + 31)
                        return v[31] ? fp_conv_pkg::int_min : fp_conv_pkg::int_max;
                p   = int'(v[30:23]) - fp_conv_pkg::exp_bias;
                mag = {40'd0, 1'b1, v[22:0]};
                mag = (p >= 23) ? mag << (p - 23) : mag >> (23 - p);
                return v[31] ? -mag[31:0] : mag[31:0];
        endfunction

        task automatic bus_access(input logic we, input logic [1:0] adr,
                                  input logic [31:0] wdata, output logic [31:0] rdata);
                int waited;
                @(negedge clk);
                wb_cyc   = 1'b1;
                wb_stb   = 1'b1;
                wb_we    = we;
                wb_adr   = adr;
                wb_dat_w = wdata;
                waited   = 0;
                do begin
                        @(negedge clk);
                        waited++;
                end while (!wb_ack && waited < 8);
                if (!wb_ack) begin
                        $display("bus access to register %0d was never acknowledged", adr);
                        errors++;
                end
                rdata  = wb_dat_r;
                wb_cyc = 1'b0;
                wb_stb = 1'b0;
                wb_we  = 1'b0;
        endtask

        task automatic bus_write(input logic [1:0] adr, input logic [31:0] data);
                logic [31:0] unused;
                bus_access(1'b1, adr, data, unused);
        endtask

        task automatic bus_read(input logic [1:0] adr, output logic [31:0] data);
                bus_access(1'b0, adr, 32'd0, data);
        endtask

        task automatic expect_word(input string what, input logic [31:0] op,
                                   input logic [31:0] expected, input logic [31:0] got);
                checks++;
                assert (got === expected) else begin
                        $display("MISMATCH at %0t: %s operand %08h expected %08h got %08h",
                                 $time, what, op, expected, got);
                        errors++;
                end
        endtask

        task automatic wait_done();
                logic [31:0] st;
                int          polls;
                polls = 0;
                do begin
                        bus_read(fp_conv_pkg::reg_status, st);
                        polls++;
                end while (!st[fp_conv_pkg::stat_done_bit] && polls < 60);
                if (!st[fp_conv_pkg::stat_done_bit]) begin
                        $display("conversion did not finish within %0d status polls", polls);
                        errors++;
                end
        endtask

        task automatic convert_and_check(input logic dir, input logic [31:0] op,
                                         input logic [31:0] expected);
                logic [31:0] got;
                bus_write(fp_conv_pkg::reg_operand, op);
                bus_write(fp_conv_pkg::reg_ctrl, dir ? ctrl_f2i : 32'd0);
                wait_done();
                bus_read(fp_conv_pkg::reg_result, got);
                expect_word(dir ? "float to int" : "int to float", op, expected, got);
        endtask

        task automatic finish_test(input string name);
                if (errors == test_mark) begin
                        $display("test %s: pass", name);
                        tests_passed++;
                end else begin
                        $display("test %s: FAIL, %0d errors", name, errors - test_mark);
                        tests_failed++;
                end
                test_mark = errors;
        endtask

        initial begin
                cycles = 0;
                while (cycles < timeout_cycles) begin
                        @(posedge clk);
                        cycles++;
                end
                $display("timeout: the run hung for %0d cycles without finishing", cycles);
                $display("Simulation failed");
                $finish;
        end

        initial begin
                logic [31:0] got, r, s, v;
                int          i;
                rst = 1'b0;
                {wb_cyc, wb_stb, wb_we} = 3'b000;
                wb_adr       = '0;
                wb_dat_w     = '0;
                lcg_state    = 32'd61702;
                errors       = 0;
                checks       = 0;
                tests_passed = 0;
                tests_failed = 0;
                test_mark    = 0;
                repeat (8) @(negedge clk);
                rst = 1'b1;

                bus_write(fp_conv_pkg::reg_operand, 32'ha5a5_5a5a);
                bus_read(fp_conv_pkg::reg_operand, got);
                expect_word("operand readback", 32'ha5a5_5a5a, 32'ha5a5_5a5a, got);
                bus_read(fp_conv_pkg::reg_ctrl, got);
                expect_word("ctrl read", 32'd0, 32'd0, got);
                finish_test("register readback");

                for (i = 0; i < 6; i++)
                        convert_and_check(1'b0, i2f_in[i], i2f_exp[i]);
                for (i = 0; i < 31; i++) begin
                        v = 32'd1 << i;
                        convert_and_check(1'b0, v, {1'b0, 8'(fp_conv_pkg::exp_bias + i), 23'd0});
                        convert_and_check(1'b0, -v, {1'b1, 8'(fp_conv_pkg::exp_bias + i), 23'd0});
                end
                finish_test("int to float exact");

                for (i = 6; i < 10; i++)
                        convert_and_check(1'b0, i2f_in[i], i2f_exp[i]);
                for (i = 0; i < 150; i++) begin
                        r = lcg_next();
                        s = lcg_next();
                        v = r >> s[28:24]; // spread the leading zero count
                        if (s[31])
                                v = -v;
                        convert_and_check(1'b0, v, i2f_model(v));
                end
                finish_test("int to float rounding");

                for (i = 0; i < 14; i++)
                        convert_and_check(1'b1, f2i_in[i], f2i_exp[i]);
                for (i = 0; i < 100; i++) begin
                        r = lcg_next();
                        s = lcg_next();
                        v = {s[23], 8'd110 + 8'(s[31:24] % 60), r[31:9]}; // 2^-17 up to 2^42
                        convert_and_check(1'b1, v, f2i_model(v));
                end
                finish_test("float to int");

                bus_write(fp_conv_pkg::reg_operand, 32'd1);
                bus_write(fp_conv_pkg::reg_ctrl, 32'd0);
                bus_read(fp_conv_pkg::reg_status, got);
                expect_word("status while busy", 32'd1, st_busy, got);
                bus_write(fp_conv_pkg::reg_operand, 32'h4040_0000);
                bus_write(fp_conv_pkg::reg_ctrl, ctrl_f2i); // lands while busy
                wait_done();
                bus_read(fp_conv_pkg::reg_result, got);
                expect_word("result after ignored start", 32'd1, 32'h3f80_0000, got);
                bus_read(fp_conv_pkg::reg_status, got);
                expect_word("status after done", 32'd1, st_done, got);
                bus_read(fp_conv_pkg::reg_status, got);
                expect_word("status read again", 32'd1, st_done, got);
                finish_test("status and busy");

                bus_write(fp_conv_pkg::reg_operand, 32'd1);
                bus_write(fp_conv_pkg::reg_ctrl, 32'd0);
                repeat (3) @(negedge clk);
                rst = 1'b0;
                repeat (8) @(negedge clk);
                rst = 1'b1;
                bus_read(fp_conv_pkg::reg_status, got);
                expect_word("status after reset", 32'd1, 32'd0, got);
                repeat (50) @(negedge clk);
                bus_read(fp_conv_pkg::reg_status, got);
                expect_word("status long after reset", 32'd1, 32'd0, got);
                convert_and_check(1'b0, 32'd5, 32'h40a0_0000);
                finish_test("reset during conversion");

                if (dut_i.sva_i.sva_errors != 0) begin
                        $display("bound assertions failed %0d times", dut_i.sva_i.sva_errors);
                        errors++;
                end
                finish_test("bus protocol and handshakes");

                $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                         tests_passed, tests_failed, checks, errors);
                if (tests_failed == 0 && errors == 0)
                        $display("Simulation completed successfully");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

//--- sim.f
verilog/fp_conv_pkg.sv
verilog/int_to_float.sv
verilog/float_to_int.sv
verilog/fp_conv_wb_regs.sv
verilog/fp_conv_top.sv
verif/fp_conv_sva.sv
verif/fp_conv_tb.sv
